// ==== list.f ====
+incdir+logic
logic/mips_pkg.sv
logic/main_control.sv
logic/reg_bank.sv
logic/branch_jump_unit.sv
logic/id_stage.sv
tests/id_stage_checker.sv
tests/id_stage_scoreboard.sv
tests/id_stage_tb.sv

// ==== logic/branch_jump_unit.sv ====
`timescale 1ns/1ns
`include "mips_consts.svh"

module branch_jump_unit (
    input  logic [`MIPS_XLEN-1:0] i_instr,
    input  logic [`MIPS_XLEN-1:0] i_pc,
    input  mips_pkg::ctrl_t       i_ctrl,
    input  logic                  i_bubble,
    input  logic [`MIPS_XLEN-1:0] i_reg_a,
    input  logic [`MIPS_XLEN-1:0] i_reg_b,
    output logic [`MIPS_XLEN-1:0] o_imm,
    output logic [`MIPS_RAW-1:0]  o_rd,
    output mips_pkg::redirect_t   o_redirect
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    logic        is_rtype;
    logic        is_j;
    logic        is_jal;
    logic        is_jr;
    logic        is_jalr;
    logic        operands_eq;

    assign opcode = i_instr[31:26];
    assign funct  = i_instr[5:0];
    assign imm16  = i_instr[15:0];

    assign is_rtype = (opcode == mips_pkg::OP_RTYPE);
    assign is_j     = (opcode == mips_pkg::OP_J);
    assign is_jal   = (opcode == mips_pkg::OP_JAL);
    assign is_jr    = is_rtype && (funct == mips_pkg::FN_JR);
    assign is_jalr  = is_rtype && (funct == mips_pkg::FN_JALR);

    //////////////////////////////////////////////////////////////////////
    // Immediate and branch
    //////////////////////////////////////////////////////////////////////

    // Logic immediates are zero extended, LUI goes to the upper half
    always_comb begin
        if (opcode == mips_pkg::OP_ANDI || opcode == mips_pkg::OP_ORI) begin
            o_imm = {16'h0000, imm16};
        end else if (opcode == mips_pkg::OP_LUI) begin
            o_imm = {imm16, 16'h0000};
        end else begin
            o_imm = {{16{imm16[15]}}, imm16};
        end
    end

    assign operands_eq = (i_reg_a == i_reg_b);

    assign o_redirect.pc_branch    = i_pc + (o_imm << 2);
    // mem.branch already cleared by a bubble
    assign o_redirect.branch_taken = i_ctrl.mem.branch & (operands_eq ^ i_ctrl.is_bne);

    //////////////////////////////////////////////////////////////////////
    // Jumps and links
    //////////////////////////////////////////////////////////////////////

    assign o_redirect.ret     = is_jr | is_jalr;
    assign o_redirect.jump    = ~i_bubble & (is_j | is_jal | is_jr | is_jalr);
    assign o_redirect.pc_jump = (is_jr | is_jalr) ? i_reg_a
                                                  : {i_pc[31:28], i_instr[25:0], 2'b00};

    assign o_redirect.link           = ~i_bubble & (is_jal | is_jalr);
    assign o_redirect.return_address = i_pc + `MIPS_XLEN'd4;

    // Destination: r31 for JAL, rd for R-type, rt for the rest
    always_comb begin
        if (is_jal) begin
            o_rd = `MIPS_RAW'd31;
        end else if (is_rtype) begin
            o_rd = i_instr[15:11];
        end else begin
            o_rd = i_instr[20:16];
        end
    end

endmodule

// ==== logic/id_stage.sv ====
`timescale 1ns/1ns
`include "mips_consts.svh"

module id_stage (
    input  logic                  i_clock,
    input  logic                  i_rst,
    input  logic [`MIPS_XLEN-1:0] i_instr,
    input  logic [`MIPS_XLEN-1:0] i_pc,
    input  logic                  i_bubble,
    input  mips_pkg::wb_port_t    i_wb,
    output mips_pkg::id_out_t     o_id,
    output mips_pkg::redirect_t   o_redirect,
    output logic                  o_halt
);

    mips_pkg::opcode_e     opcode;
    mips_pkg::funct_e      funct;
    logic [`MIPS_RAW-1:0]  rs;
    logic [`MIPS_RAW-1:0]  rt;
    mips_pkg::ctrl_t       ctrl;
    logic [`MIPS_XLEN-1:0] reg_a;
    logic [`MIPS_XLEN-1:0] reg_b;
    logic [`MIPS_XLEN-1:0] imm;
    logic [`MIPS_RAW-1:0]  rd;

    // Instruction fields
    assign opcode = mips_pkg::opcode_e'(i_instr[31:26]);
    assign funct  = mips_pkg::funct_e'(i_instr[5:0]);
    assign rs     = i_instr[25:21];
    assign rt     = i_instr[20:16];

    main_control u_main_control (
        .i_opcode (opcode),
        .i_funct  (funct),
        .i_bubble (i_bubble),
        .o_ctrl   (ctrl)
    );

    reg_bank u_reg_bank (
        .i_clock  (i_clock),
        .i_rst    (i_rst),
        .i_wb     (i_wb),
        .i_rs     (rs),
        .i_rt     (rt),
        .o_reg_a  (reg_a),
        .o_reg_b  (reg_b)
    );

    branch_jump_unit u_branch_jump (
        .i_instr    (i_instr),
        .i_pc       (i_pc),
        .i_ctrl     (ctrl),
        .i_bubble   (i_bubble),
        .i_reg_a    (reg_a),
        .i_reg_b    (reg_b),
        .o_imm      (imm),
        .o_rd       (rd),
        .o_redirect (o_redirect)
    );

    //////////////////////////////////////////////////////////////////////
    // Toward ID/EX
    //////////////////////////////////////////////////////////////////////

    assign o_id.reg_a          = reg_a;
    assign o_id.reg_b          = reg_b;
    assign o_id.imm            = imm;
    assign o_id.opcode         = opcode;
    assign o_id.rs             = rs;
    assign o_id.rt             = rt;
    assign o_id.rd             = rd;
    assign o_id.ctrl.ex        = ctrl.ex;
    assign o_id.ctrl.mem       = ctrl.mem;
    assign o_id.ctrl.wb        = ctrl.wb;
    assign o_id.ctrl.size      = ctrl.size;
    assign o_id.ctrl.is_signed = ctrl.is_signed;

    assign o_halt = ctrl.halt;

endmodule

// ==== logic/main_control.sv ====
`timescale 1ns/1ns
`include "mips_consts.svh"

module main_control (
    input  mips_pkg::opcode_e i_opcode,
    input  mips_pkg::funct_e  i_funct,
    input  logic              i_bubble,
    output mips_pkg::ctrl_t   o_ctrl
);

    mips_pkg::ctrl_t dec;

    //////////////////////////////////////////////////////////////////////
    // Raw decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        dec = '0;
        case (i_opcode)
            mips_pkg::OP_RTYPE: begin
                case (i_funct)
                    mips_pkg::FN_ADDU, mips_pkg::FN_SUBU, mips_pkg::FN_AND,
                    mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_SLT,
                    mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_JALR: begin
                        dec.ex.alu_op    = 2'd2;
                        dec.ex.reg_dst   = 1'b1;
                        dec.wb.reg_write = 1'b1;
                    end
                    // JR only redirects, nothing to write back
                    default: dec = '0;
                endcase
            end
            mips_pkg::OP_ADDI: begin
                dec.ex.alu_src   = 1'b1;
                dec.wb.reg_write = 1'b1;
            end
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_LUI, mips_pkg::OP_SLTI: begin
                dec.ex.alu_src   = 1'b1;
                dec.ex.alu_op    = 2'd3;
                dec.wb.reg_write = 1'b1;
            end
            mips_pkg::OP_LW, mips_pkg::OP_LH, mips_pkg::OP_LHU,
            mips_pkg::OP_LB, mips_pkg::OP_LBU: begin
                dec.ex.alu_src    = 1'b1;
                dec.mem.mem_read  = 1'b1;
                dec.wb.reg_write  = 1'b1;
                dec.wb.mem_to_reg = 1'b1;
                dec.is_signed     = (i_opcode == mips_pkg::OP_LW) ||
                                    (i_opcode == mips_pkg::OP_LH) ||
                                    (i_opcode == mips_pkg::OP_LB);
                if (i_opcode == mips_pkg::OP_LW) begin
                    dec.size = 2'd2;
                end else if (i_opcode == mips_pkg::OP_LH || i_opcode == mips_pkg::OP_LHU) begin
                    dec.size = 2'd1;
                end
            end
            mips_pkg::OP_SW, mips_pkg::OP_SH, mips_pkg::OP_SB: begin
                dec.ex.alu_src    = 1'b1;
                dec.mem.mem_write = 1'b1;
                if (i_opcode == mips_pkg::OP_SW) begin
                    dec.size = 2'd2;
                end else if (i_opcode == mips_pkg::OP_SH) begin
                    dec.size = 2'd1;
                end
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                dec.ex.alu_op  = 2'd1;
                dec.mem.branch = 1'b1;
                dec.is_bne     = (i_opcode == mips_pkg::OP_BNE);
            end
            // Return address lands in r31
            mips_pkg::OP_JAL: dec.wb.reg_write = 1'b1;
            `MIPS_OP_HALT:    dec.halt = 1'b1;
            default:          dec = '0;
        endcase
    end

    // Bubble squashes everything that acts later in the pipe
    always_comb begin
        o_ctrl = dec;
        if (i_bubble) begin
            o_ctrl.ex   = '0;
            o_ctrl.mem  = '0;
            o_ctrl.wb   = '0;
            o_ctrl.halt = 1'b0;
        end
    end

endmodule

// ==== logic/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Datapath word width
`define MIPS_XLEN 32

// Register bank geometry
`define MIPS_NREGS 32
`define MIPS_RAW 5

// Opcode that stops the pipeline
`define MIPS_OP_HALT 6'h3F

`endif

// ==== logic/mips_pkg.sv ====
`include "mips_consts.svh"

package mips_pkg;

    // Primary opcodes handled by the decoder
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0A,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_LUI   = 6'h0F,
        OP_LB    = 6'h20,
        OP_LH    = 6'h21,
        OP_LW    = 6'h23,
        OP_LBU   = 6'h24,
        OP_LHU   = 6'h25,
        OP_SB    = 6'h28,
        OP_SH    = 6'h29,
        OP_SW    = 6'h2B,
        OP_HALT  = `MIPS_OP_HALT
    } opcode_e;

    // R-type function field
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A
    } funct_e;

    ////////////////////////////////////////////////////////////////////
    // Control groups carried down the pipe
    ////////////////////////////////////////////////////////////////////

    // alu_op: 0 add, 1 sub, 2 R-type, 3 immediate logic
    typedef struct packed {
        logic       alu_src;
        logic [1:0] alu_op;
        logic       reg_dst;
    } ctrl_ex_t;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
        logic branch;
    } ctrl_mem_t;

    typedef struct packed {
        logic reg_write;
        logic mem_to_reg;
    } ctrl_wb_t;

    // size: 0 byte, 1 half, 2 word
    typedef struct packed {
        ctrl_ex_t   ex;
        ctrl_mem_t  mem;
        ctrl_wb_t   wb;
        logic [1:0] size;
        logic       is_signed;
        logic       is_bne;
        logic       halt;
    } ctrl_t;

    // Subset of ctrl_t that goes on to ID/EX
    typedef struct packed {
        ctrl_ex_t   ex;
        ctrl_mem_t  mem;
        ctrl_wb_t   wb;
        logic [1:0] size;
        logic       is_signed;
    } id_ctrl_t;

    ////////////////////////////////////////////////////////////////////
    // Stage boundaries
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                  we;
        logic [`MIPS_RAW-1:0]  addr;
        logic [`MIPS_XLEN-1:0] data;
    } wb_port_t;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0] reg_a;
        logic [`MIPS_XLEN-1:0] reg_b;
        logic [`MIPS_XLEN-1:0] imm;
        opcode_e               opcode;
        logic [`MIPS_RAW-1:0]  rs;
        logic [`MIPS_RAW-1:0]  rt;
        logic [`MIPS_RAW-1:0]  rd;
        id_ctrl_t              ctrl;
    } id_out_t;

    typedef struct packed {
        logic                  branch_taken;
        logic [`MIPS_XLEN-1:0] pc_branch;
        logic                  jump;
        logic [`MIPS_XLEN-1:0] pc_jump;
        logic                  ret;
        logic                  link;
        logic [`MIPS_XLEN-1:0] return_address;
    } redirect_t;

endpackage

// ==== logic/reg_bank.sv ====
`timescale 1ns/1ns
`include "mips_consts.svh"

module reg_bank (
    input  logic                  i_clock,
    input  logic                  i_rst,
    input  mips_pkg::wb_port_t    i_wb,
    input  logic [`MIPS_RAW-1:0]  i_rs,
    input  logic [`MIPS_RAW-1:0]  i_rt,
    output logic [`MIPS_XLEN-1:0] o_reg_a,
    output logic [`MIPS_XLEN-1:0] o_reg_b
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

    // Single write port, r0 stays at its reset value
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.we && (i_wb.addr != '0)) begin
            regs[i_wb.addr] <= i_wb.data;
        end
    end

    // Reads see the old value during a write cycle
    assign o_reg_a = regs[i_rs];
    assign o_reg_b = regs[i_rt];

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module id_stage_tb \
    -Mdir "$BUILD_DIR" -o id_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/id_stage_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== tests/id_stage_checker.sv ====
`timescale 1ns/1ns

module id_stage_checker (
    input logic                i_clock,
    input logic                i_rst,
    input logic                i_bubble,
    input mips_pkg::id_out_t   i_id,
    input mips_pkg::redirect_t i_redirect,
    input logic                i_halt
);

    int unsigned fail_count = 0;

    // A bubble leaves nothing active for later stages
    bubble_clears: assert property (@(posedge i_clock)
        i_bubble |-> (i_id.ctrl.ex == '0 && i_id.ctrl.mem == '0 && i_id.ctrl.wb == '0 &&
                      !i_redirect.branch_taken && !i_redirect.jump &&
                      !i_redirect.link && !i_halt))
        else begin
            fail_count++;
            $error("control still active under a bubble");
        end

    // r0 reads zero on both ports
    r0_port_a: assert property (@(posedge i_clock) disable iff (i_rst)
        (i_id.rs == '0) |-> (i_id.reg_a == '0))
        else begin
            fail_count++;
            $error("register 0 read nonzero on port A");
        end

    r0_port_b: assert property (@(posedge i_clock) disable iff (i_rst)
        (i_id.rt == '0) |-> (i_id.reg_b == '0))
        else begin
            fail_count++;
            $error("register 0 read nonzero on port B");
        end

    // Only one redirect source at a time
    redirect_exclusive: assert property (@(posedge i_clock)
        !(i_redirect.jump && i_redirect.branch_taken))
        else begin
            fail_count++;
            $error("jump and branch taken asserted together");
        end

endmodule

bind id_stage id_stage_checker u_checker (
    .i_clock    (i_clock),
    .i_rst      (i_rst),
    .i_bubble   (i_bubble),
    .i_id       (o_id),
    .i_redirect (o_redirect),
    .i_halt     (o_halt)
);

// ==== tests/id_stage_scoreboard.sv ====
`timescale 1ns/1ns
`include "mips_consts.svh"

module id_stage_scoreboard (
    input  logic                  i_clock,
    input  logic                  i_rst,
    input  logic [`MIPS_XLEN-1:0] i_instr,
    input  logic [`MIPS_XLEN-1:0] i_pc,
    input  logic                  i_bubble,
    input  mips_pkg::wb_port_t    i_wb,
    input  mips_pkg::id_out_t     i_id,
    input  mips_pkg::redirect_t   i_redirect,
    input  logic                  i_halt,
    output int unsigned           o_errors,
    output int unsigned           o_checks
);

    logic [`MIPS_XLEN-1:0] shadow [`MIPS_NREGS];
    int unsigned           errors = 0;
    int unsigned           checks = 0;

    assign o_errors = errors;
    assign o_checks = checks;

    //////////////////////////////////////////////////////////////////////
    // Reference decoder
    //////////////////////////////////////////////////////////////////////

    function automatic mips_pkg::ctrl_t expected_ctrl(input logic [5:0] op,
                                                      input logic [5:0] fn,
                                                      input logic       bubble);
        mips_pkg::ctrl_t c;
        c = '0;
        case (op)
            mips_pkg::OP_RTYPE: begin
                // JR writes nothing, unknown functions are no-ops
                if (fn inside {6'h00, 6'h02, 6'h09, 6'h21, 6'h23, 6'h24, 6'h25, 6'h26,
                               6'h2A}) begin
                    c.ex.alu_op    = 2'd2;
                    c.ex.reg_dst   = 1'b1;
                    c.wb.reg_write = 1'b1;
                end
            end
            mips_pkg::OP_ADDI: begin
                c.ex.alu_src   = 1'b1;
                c.wb.reg_write = 1'b1;
            end
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_LUI, mips_pkg::OP_SLTI: begin
                c.ex.alu_src   = 1'b1;
                c.ex.alu_op    = 2'd3;
                c.wb.reg_write = 1'b1;
            end
            mips_pkg::OP_LW, mips_pkg::OP_LH, mips_pkg::OP_LHU, mips_pkg::OP_LB,
            mips_pkg::OP_LBU: begin
                c.ex.alu_src    = 1'b1;
                c.mem.mem_read  = 1'b1;
                c.wb.reg_write  = 1'b1;
                c.wb.mem_to_reg = 1'b1;
            end
            mips_pkg::OP_SW, mips_pkg::OP_SH, mips_pkg::OP_SB: begin
                c.ex.alu_src   = 1'b1;
                c.mem.mem_write = 1'b1;
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                c.ex.alu_op  = 2'd1;
                c.mem.branch = 1'b1;
                c.is_bne     = (op == mips_pkg::OP_BNE);
            end
            mips_pkg::OP_JAL:  c.wb.reg_write = 1'b1;
            mips_pkg::OP_HALT: c.halt = 1'b1;
            default:           c = '0;
        endcase
        if (op inside {mips_pkg::OP_LW, mips_pkg::OP_SW}) begin
            c.size = 2'd2;
        end
        if (op inside {mips_pkg::OP_LH, mips_pkg::OP_LHU, mips_pkg::OP_SH}) begin
            c.size = 2'd1;
        end
        c.is_signed = (op inside {mips_pkg::OP_LW, mips_pkg::OP_LH, mips_pkg::OP_LB});
        // Size and signedness survive a bubble
        if (bubble) begin
            c.ex   = '0;
            c.mem  = '0;
            c.wb   = '0;
            c.halt = 1'b0;
        end
        return c;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h at %0t ns", name, exp, act, $time);
        end
    endtask

    task automatic check_outputs();
        mips_pkg::ctrl_t       c;
        logic [5:0]            op;
        logic [5:0]            fn;
        logic [`MIPS_XLEN-1:0] a;
        logic [`MIPS_XLEN-1:0] b;
        logic [`MIPS_XLEN-1:0] imm;
        logic [`MIPS_RAW-1:0]  rd;
        logic                  via_reg;
        logic                  is_jal;
        op      = i_instr[31:26];
        fn      = i_instr[5:0];
        a       = shadow[i_instr[25:21]];
        b       = shadow[i_instr[20:16]];
        c       = expected_ctrl(op, fn, i_bubble);
        is_jal  = (op == mips_pkg::OP_JAL);
        via_reg = (op == mips_pkg::OP_RTYPE) && (fn inside {6'h08, 6'h09});
        if (op inside {mips_pkg::OP_ANDI, mips_pkg::OP_ORI}) begin
            imm = {16'h0000, i_instr[15:0]};
        end else if (op == mips_pkg::OP_LUI) begin
            imm = {i_instr[15:0], 16'h0000};
        end else begin
            imm = {{16{i_instr[15]}}, i_instr[15:0]};
        end
        if (is_jal) begin
            rd = 5'd31;
        end else if (op == mips_pkg::OP_RTYPE) begin
            rd = i_instr[15:11];
        end else begin
            rd = i_instr[20:16];
        end

        compare_value("reg_bank rs read", a, i_id.reg_a);
        compare_value("reg_bank rt read", b, i_id.reg_b);
        compare_value("field split", 32'({op, i_instr[25:16]}),
                      32'({i_id.opcode, i_id.rs, i_id.rt}));
        compare_value("destination reg", 32'(rd), 32'(i_id.rd));
        compare_value("immediate", imm, i_id.imm);
        compare_value("control decode", 32'({c.ex, c.mem, c.wb, c.size, c.is_signed}),
                      32'(i_id.ctrl));
        compare_value("branch target", i_pc + (imm << 2), i_redirect.pc_branch);
        compare_value("branch taken", 32'(c.mem.branch && ((a == b) != c.is_bne)),
                      32'(i_redirect.branch_taken));
        compare_value("jump", 32'(!i_bubble && (via_reg || is_jal || op == mips_pkg::OP_J)),
                      32'(i_redirect.jump));
        compare_value("jump target", via_reg ? a : {i_pc[31:28], i_instr[25:0], 2'b00},
                      i_redirect.pc_jump);
        compare_value("return via register", 32'(via_reg), 32'(i_redirect.ret));
        compare_value("link", 32'(!i_bubble && (is_jal || (via_reg && fn == 6'h09))),
                      32'(i_redirect.link));
        compare_value("return address", i_pc + 32'd4, i_redirect.return_address);
        compare_value("halt", 32'(c.halt), 32'(i_halt));
    endtask

    // Compare against the old contents, then mirror this edge's write
    always @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                shadow[i] = '0;
            end
        end else begin
            check_outputs();
            if (i_wb.we && i_wb.addr != '0) begin
                shadow[i_wb.addr] = i_wb.data;
            end
        end
    end

endmodule

// ==== tests/id_stage_tb.sv ====
`timescale 1ns/1ns
`include "mips_consts.svh"

module id_stage_tb;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 2;
    localparam int FILL_CYCLES   = 40;
    localparam int RANDOM_CYCLES = 400;
    localparam int TIMEOUT_NS    = (RESET_CYCLES + FILL_CYCLES + RANDOM_CYCLES + 20) * CLK_PERIOD;

    // Opcode pools, 6 bits per entry
    localparam logic [18*6-1:0] OPCODES = {6'h02, 6'h03, 6'h04, 6'h05, 6'h08, 6'h0A, 6'h0C,
                                           6'h0D, 6'h0F, 6'h20, 6'h21, 6'h23, 6'h24, 6'h25,
                                           6'h28, 6'h29, 6'h2B, 6'h3F};
    localparam logic [8*6-1:0]  BAD_OPCODES = {6'h01, 6'h06, 6'h07, 6'h10, 6'h1F, 6'h30,
                                               6'h38, 6'h3E};
    localparam logic [10*6-1:0] FUNCTS = {6'h00, 6'h02, 6'h08, 6'h09, 6'h21, 6'h23, 6'h24,
                                          6'h25, 6'h26, 6'h2A};

    logic                  clock;
    logic                  rst;
    logic [`MIPS_XLEN-1:0] instr;
    logic [`MIPS_XLEN-1:0] pc;
    logic                  bubble;
    mips_pkg::wb_port_t    wb;
    mips_pkg::id_out_t     id_out;
    mips_pkg::redirect_t   redirect;
    logic                  halt;
    int unsigned           errors;
    int unsigned           checks;

    always #(CLK_PERIOD / 2) clock = ~clock;

    id_stage u_dut (
        .i_clock    (clock),
        .i_rst      (rst),
        .i_instr    (instr),
        .i_pc       (pc),
        .i_bubble   (bubble),
        .i_wb       (wb),
        .o_id       (id_out),
        .o_redirect (redirect),
        .o_halt     (halt)
    );

    id_stage_scoreboard u_scoreboard (
        .i_clock    (clock),
        .i_rst      (rst),
        .i_instr    (instr),
        .i_pc       (pc),
        .i_bubble   (bubble),
        .i_wb       (wb),
        .i_id       (id_out),
        .i_redirect (redirect),
        .i_halt     (halt),
        .o_errors   (errors),
        .o_checks   (checks)
    );

    function automatic logic [31:0] random_instr();
        logic [31:0] word;
        int unsigned pick;
        int unsigned idx;
        word = $urandom;
        pick = $urandom_range(0, 99);
        if (pick < 35) begin
            word[31:26] = 6'h00;
            // A few R-types keep a random, mostly undefined, function code
            if (pick < 31) begin
                idx = $urandom_range(0, 9);
                word[5:0] = FUNCTS[6*idx +: 6];
            end
        end else if (pick < 92) begin
            idx = $urandom_range(0, 17);
            word[31:26] = OPCODES[6*idx +: 6];
        end else begin
            idx = $urandom_range(0, 7);
            word[31:26] = BAD_OPCODES[6*idx +: 6];
        end
        // rs == rt now and then, so BEQ sees equal operands
        if ($urandom_range(0, 3) == 0) begin
            word[20:16] = word[25:21];
        end
        return word;
    endfunction

    task automatic drive_cycle(input logic fill);
        logic [31:0] rnd;
        @(negedge clock);
        instr  = random_instr();
        rnd    = $urandom;
        pc     = {rnd[31:2], 2'b00};
        bubble = !fill && ($urandom_range(0, 9) == 0);
        wb.we  = fill || ($urandom_range(0, 1) == 1);
        rnd    = $urandom;
        // Half the writes target this cycle's rs
        wb.addr = ($urandom_range(0, 1) == 1) ? instr[25:21] : rnd[4:0];
        rnd     = $urandom;
        wb.data = ($urandom_range(0, 1) == 1) ? {30'd0, rnd[1:0]} : $urandom;
    endtask

    initial begin
        void'($urandom(73));
        clock  = 1'b0;
        rst    = 1'b1;
        bubble = 1'b1;
        instr  = '0;
        pc     = '0;
        wb     = '0;
        repeat (RESET_CYCLES) @(negedge clock);
        rst = 1'b0;
        repeat (FILL_CYCLES) drive_cycle(1'b1);
        repeat (RANDOM_CYCLES) drive_cycle(1'b0);
        @(negedge clock);
        $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
                 checks, errors, u_dut.u_checker.fail_count);
        if (errors == 0 && u_dut.u_checker.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: stimulus did not finish within %0d ns", TIMEOUT_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule
